/* source/cfg_ram_macros.svh */
// Shared widths and RAM latency for the config RAM block, included by every RTL file that needs them
`ifndef CFG_RAM_MACROS_SVH
`define CFG_RAM_MACROS_SVH

//////////////////////////////////////////////////
// Geometry
//////////////////////////////////////////////////

// Word address width, 32 words per channel table
`define CFG_ADDR_BITS 5

// Payload width of one config word
`define CFG_DATA_BITS 32

//////////////////////////////////////////////////
// Timing
//////////////////////////////////////////////////

// Cycles from read enable to read data at the RAM port
// Address register plus output register
`define CFG_RD_LAT 2

`endif

/* source/cfg_ram_pkg.sv */
// Bus, engine, memory and RAM word types shared by the config RAM block modules
`include "cfg_ram_macros.svh"

package cfg_ram_pkg;

    //////////////////////////////////////////////////
    // CPU register bus
    //////////////////////////////////////////////////

    // Request held by the master until rdy
    // page 0 is the RAM, page 1 the status registers
    typedef struct packed {
        logic                      cs;
        logic                      wr;
        logic                      page;
        logic [`CFG_ADDR_BITS-1:0] addr;
        logic [`CFG_DATA_BITS-1:0] wdata;
    } cpu_req_t;

    // Response, rdy is a one-cycle pulse
    typedef struct packed {
        logic                      rdy;
        logic [`CFG_DATA_BITS-1:0] rdata;
    } cpu_rsp_t;

    //////////////////////////////////////////////////
    // Engine and memory side
    //////////////////////////////////////////////////

    // Engine read request
    typedef struct packed {
        logic                      re;
        logic [`CFG_ADDR_BITS-1:0] ra;
    } eng_rd_t;

    // Stored word, even parity on top
    typedef struct packed {
        logic                      par;
        logic [`CFG_DATA_BITS-1:0] data;
    } ram_word_t;

    // One write port and one read port per cycle
    typedef struct packed {
        logic                      we;
        logic [`CFG_ADDR_BITS-1:0] wa;
        ram_word_t                 wd;
        logic                      re;
        logic [`CFG_ADDR_BITS-1:0] ra;
    } mem_cmd_t;

endpackage

/* source/cpu_bus_decode.sv */
// CPU bus front end: turns a held request into an enable level and first-cycle strobes per page
module cpu_bus_decode
(
    input  logic                  clk,
    input  logic                  rst,
    input  cfg_ram_pkg::cpu_req_t cpu_req,
    output logic                  ram_en,
    output logic                  ram_ws,
    output logic                  ram_rs,
    output logic                  reg_en,
    output logic                  reg_ws,
    output logic                  reg_rs
);

    // Set after the first cycle of a request
    logic issued;
    // High only on the first cycle cs is seen
    logic first;

    //////////////////////////////////////////////////
    // One strobe per request
    //////////////////////////////////////////////////

    // Cleared as soon as cs drops, master idles at least one cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            issued <= 1'b0;
        end
        else if (!cpu_req.cs)
        begin
            issued <= 1'b0;
        end
        else
        begin
            issued <= 1'b1;
        end
    end

    assign first = cpu_req.cs & ~issued;

    //////////////////////////////////////////////////
    // Page steering
    //////////////////////////////////////////////////

    // RAM page
    assign ram_en = cpu_req.cs & ~cpu_req.page;
    assign ram_ws = first & ~cpu_req.page & cpu_req.wr;
    assign ram_rs = first & ~cpu_req.page & ~cpu_req.wr;

    // Status page
    assign reg_en = cpu_req.cs & cpu_req.page;
    assign reg_ws = first & cpu_req.page & cpu_req.wr;
    assign reg_rs = first & cpu_req.page & ~cpu_req.wr;

    // Request fields frozen for the whole access, the RAM path samples addr late
    a_req_stable : assert property (
        @(posedge clk) disable iff (rst)
        (cpu_req.cs && $past(cpu_req.cs)) |->
            ($stable(cpu_req.addr) && $stable(cpu_req.wr) && $stable(cpu_req.page))
    );

endmodule

/* source/cfg_ram_access.sv */
// RAM port arbiter between engine and CPU with parity generation and checking, placed ahead of the RAM store
`include "cfg_ram_macros.svh"

module cfg_ram_access
(
    input  logic                         clk,
    input  logic                         rst,
    // CPU side, from the bus decoder
    input  logic                         ram_en,
    input  logic                         ram_ws,
    input  logic                         ram_rs,
    input  logic [`CFG_ADDR_BITS-1:0]    addr,
    input  logic [`CFG_DATA_BITS-1:0]    wdata,
    // Engine side
    input  cfg_ram_pkg::eng_rd_t         eng,
    input  logic                         eng_active,
    output logic [`CFG_DATA_BITS-1:0]    eng_rdd,
    // RAM store
    output cfg_ram_pkg::mem_cmd_t        mem_cmd,
    input  cfg_ram_pkg::ram_word_t       rd_word,
    // Status registers
    input  logic                         par_force,
    input  logic                         par_dis,
    output logic                         ram_rdy,
    output logic [`CFG_DATA_BITS-1:0]    ram_rdata,
    output logic                         par_err
);

    localparam int LAT = `CFG_RD_LAT;

    // Engine read this cycle
    logic                         eng_rd;
    // Write path
    logic                         wr_req;
    logic                         wr_d1;
    logic                         wr_ok;
    logic                         par_d1;
    logic                         par_d2;
    // Read path
    logic                         rd_req;
    logic                         rd_pend;
    logic                         rd_grant;
    logic                         rd_any;
    logic [`CFG_ADDR_BITS-1:0]    rd_addr;
    logic                         wr_clash;
    // Delay lines whose last tap lines up with registered read data
    logic [LAT:0]                 ok_pipe;
    logic [LAT:0]                 re_pipe;
    cfg_ram_pkg::ram_word_t       rd_q;
    logic                         par_bad;

    //////////////////////////////////////////////////
    // Write path
    //////////////////////////////////////////////////

    assign wr_req = ram_ws & ram_en;

    // Write reaches the RAM two cycles after its strobe
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_d1 <= 1'b0;
            wr_ok <= 1'b0;
        end
        else
        begin
            wr_d1 <= wr_req;
            wr_ok <= wr_d1;
        end
    end

    // Even parity with the second stage flipped on force
    always_ff @(posedge clk)
    begin
        par_d1 <= ^wdata;
        par_d2 <= par_d1 ^ par_force;
    end

    //////////////////////////////////////////////////
    // Read arbitration
    //////////////////////////////////////////////////

    assign rd_req = ram_rs & ram_en;
    assign eng_rd = eng.re & eng_active;

    // CPU goes when the engine is idle or wants the same word
    assign rd_grant = rd_pend & (~eng_rd | (eng.ra == addr));

    // Pending CPU read that drops with the request
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rd_pend <= 1'b0;
        end
        else if (!ram_en)
        begin
            rd_pend <= 1'b0;
        end
        else if (rd_grant)
        begin
            rd_pend <= 1'b0;
        end
        else if (rd_req)
        begin
            rd_pend <= 1'b1;
        end
    end

    // Engine address owns the port whenever it reads
    assign rd_any  = eng_rd | rd_grant;
    assign rd_addr = eng_rd ? eng.ra : addr;

    // Same-address write in this cycle kills the read
    assign wr_clash = wr_ok & (addr == rd_addr);

    always_comb
    begin
        mem_cmd.we      = wr_ok;
        mem_cmd.wa      = addr;
        mem_cmd.wd.par  = par_d2;
        mem_cmd.wd.data = wdata;
        mem_cmd.re      = rd_any & ~wr_clash;
        mem_cmd.ra      = rd_addr;
    end

    // Engine data straight off the RAM output
    assign eng_rdd = rd_word.data;

    //////////////////////////////////////////////////
    // CPU ready and read data
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ok_pipe <= '0;
            re_pipe <= '0;
        end
        else
        begin
            ok_pipe <= {ok_pipe[LAT-1:0], rd_grant | wr_ok};
            re_pipe <= {re_pipe[LAT-1:0], mem_cmd.re};
        end
    end

    // One register stage after the RAM
    always_ff @(posedge clk)
    begin
        rd_q <= rd_word;
    end

    assign ram_rdy   = ok_pipe[LAT];
    assign ram_rdata = rd_q.data;

    //////////////////////////////////////////////////
    // Parity check
    //////////////////////////////////////////////////

    // Odd overall count means a bad word
    assign par_bad = re_pipe[LAT] & ~par_dis & (^{rd_q.par, rd_q.data});

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            par_err <= 1'b0;
        end
        else
        begin
            par_err <= par_bad;
        end
    end

    // Master keeps cs up until rdy
    a_rdy_in_req : assert property (
        @(posedge clk) disable iff (rst)
        ram_rdy |-> ram_en
    );

endmodule

/* source/cfg_ram_store.sv */
// Config word memory: one write port, one read port, registered read address and output
`include "cfg_ram_macros.svh"

module cfg_ram_store
#(
    parameter type word_t = logic [`CFG_DATA_BITS-1:0]
)
(
    input  logic                         clk,
    input  logic                         we,
    input  logic [`CFG_ADDR_BITS-1:0]    wa,
    input  word_t                        wd,
    input  logic                         re,
    input  logic [`CFG_ADDR_BITS-1:0]    ra,
    output word_t                        rd_word
);

    localparam int DEPTH = 2 ** `CFG_ADDR_BITS;

    word_t                        mem [DEPTH];
    // Read stage one
    logic                         re_q;
    logic [`CFG_ADDR_BITS-1:0]    ra_q;

    // Pipeline below is built for exactly two stages
    if (`CFG_RD_LAT != 2)
    begin : g_lat_check
        $error("cfg_ram_store supports a read latency of 2 only");
    end

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[wa] <= wd;
        end
    end

    //////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////

    // Address and enable captured first
    always_ff @(posedge clk)
    begin
        re_q <= re;
        ra_q <= ra;
    end

    // Output register, holds on idle cycles
    always_ff @(posedge clk)
    begin
        if (re_q)
        begin
            rd_word <= mem[ra_q];
        end
    end

endmodule

/* source/cfg_status_regs.sv */
// Status page: parity control bits, sticky parity flag and the CPU response mux
`include "cfg_ram_macros.svh"

module cfg_status_regs
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         reg_en,
    input  logic                         reg_ws,
    input  logic                         reg_rs,
    input  logic [`CFG_ADDR_BITS-1:0]    addr,
    input  logic [`CFG_DATA_BITS-1:0]    wdata,
    input  logic                         par_err,
    input  logic                         ram_rdy,
    input  logic [`CFG_DATA_BITS-1:0]    ram_rdata,
    output logic                         par_force,
    output logic                         par_dis,
    output logic                         par_flag,
    output cfg_ram_pkg::cpu_rsp_t        cpu_rsp
);

    // Register map
    localparam logic [`CFG_ADDR_BITS-1:0] CTRL_ADDR = `CFG_ADDR_BITS'(0);
    localparam logic [`CFG_ADDR_BITS-1:0] FLAG_ADDR = `CFG_ADDR_BITS'(1);

    logic                         ctrl_we;
    logic                         flag_clr;
    logic                         reg_rdy;
    logic [`CFG_DATA_BITS-1:0]    reg_rdata;

    assign ctrl_we  = reg_en & reg_ws & (addr == CTRL_ADDR);
    assign flag_clr = reg_en & reg_ws & (addr == FLAG_ADDR) & wdata[0];

    //////////////////////////////////////////////////
    // Control and sticky flag
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            par_force <= 1'b0;
            par_dis   <= 1'b0;
            par_flag  <= 1'b0;
            reg_rdy   <= 1'b0;
        end
        else
        begin
            if (ctrl_we)
            begin
                par_force <= wdata[0];
                par_dis   <= wdata[1];
            end
            // New error beats a clear
            if (par_err)
            begin
                par_flag <= 1'b1;
            end
            else if (flag_clr)
            begin
                par_flag <= 1'b0;
            end
            // Status access acked one cycle later
            reg_rdy <= reg_en & (reg_ws | reg_rs);
        end
    end

    //////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////

    always_comb
    begin
        case (addr)
            CTRL_ADDR: reg_rdata = {{(`CFG_DATA_BITS-2){1'b0}}, par_dis, par_force};
            FLAG_ADDR: reg_rdata = {{(`CFG_DATA_BITS-1){1'b0}}, par_flag};
            default:   reg_rdata = '0;
        endcase
    end

    // Page picked by whichever request is open
    assign cpu_rsp.rdy   = ram_rdy | reg_rdy;
    assign cpu_rsp.rdata = reg_en ? reg_rdata : ram_rdata;

endmodule

/* source/cfg_ram_sys.sv */
// Top of the config RAM block: bus decode, access arbiter, RAM store and status registers
`include "cfg_ram_macros.svh"

module cfg_ram_sys
(
    input  logic                         clk,
    input  logic                         rst,
    input  cfg_ram_pkg::cpu_req_t        cpu_req,
    output cfg_ram_pkg::cpu_rsp_t        cpu_rsp,
    input  cfg_ram_pkg::eng_rd_t         eng,
    input  logic                         eng_active,
    output logic [`CFG_DATA_BITS-1:0]    eng_rdd,
    output logic                         par_flag
);

    // Decoder outputs
    logic                         ram_en;
    logic                         ram_ws;
    logic                         ram_rs;
    logic                         reg_en;
    logic                         reg_ws;
    logic                         reg_rs;
    // RAM side
    cfg_ram_pkg::mem_cmd_t        mem_cmd;
    cfg_ram_pkg::ram_word_t       rd_word;
    // Access to status
    logic                         ram_rdy;
    logic [`CFG_DATA_BITS-1:0]    ram_rdata;
    logic                         par_err;
    logic                         par_force;
    logic                         par_dis;

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////

    cpu_bus_decode u_decode
    (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .ram_en  (ram_en),
        .ram_ws  (ram_ws),
        .ram_rs  (ram_rs),
        .reg_en  (reg_en),
        .reg_ws  (reg_ws),
        .reg_rs  (reg_rs)
    );

    //////////////////////////////////////////////////
    // Arbiter and memory
    //////////////////////////////////////////////////

    cfg_ram_access u_access
    (
        .clk        (clk),
        .rst        (rst),
        .ram_en     (ram_en),
        .ram_ws     (ram_ws),
        .ram_rs     (ram_rs),
        .addr       (cpu_req.addr),
        .wdata      (cpu_req.wdata),
        .eng        (eng),
        .eng_active (eng_active),
        .eng_rdd    (eng_rdd),
        .mem_cmd    (mem_cmd),
        .rd_word    (rd_word),
        .par_force  (par_force),
        .par_dis    (par_dis),
        .ram_rdy    (ram_rdy),
        .ram_rdata  (ram_rdata),
        .par_err    (par_err)
    );

    // Word type carries the parity bit
    cfg_ram_store #(.word_t(cfg_ram_pkg::ram_word_t)) u_store
    (
        .clk     (clk),
        .we      (mem_cmd.we),
        .wa      (mem_cmd.wa),
        .wd      (mem_cmd.wd),
        .re      (mem_cmd.re),
        .ra      (mem_cmd.ra),
        .rd_word (rd_word)
    );

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////

    cfg_status_regs u_status
    (
        .clk       (clk),
        .rst       (rst),
        .reg_en    (reg_en),
        .reg_ws    (reg_ws),
        .reg_rs    (reg_rs),
        .addr      (cpu_req.addr),
        .wdata     (cpu_req.wdata),
        .par_err   (par_err),
        .ram_rdy   (ram_rdy),
        .ram_rdata (ram_rdata),
        .par_force (par_force),
        .par_dis   (par_dis),
        .par_flag  (par_flag),
        .cpu_rsp   (cpu_rsp)
    );

endmodule

/* tests/cfg_ram_sys_tb.sv */
// Testbench for the config RAM block that runs the command file against random engine reads
`include "cfg_ram_macros.svh"

module cfg_ram_sys_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LINES  = 64;
    localparam int INIT_WORDS = 16;
    localparam int RDY_LIMIT  = 200;

    logic                          clk;
    logic                          rst = 1'b1;
    cfg_ram_pkg::cpu_req_t         cpu_req = '0;
    cfg_ram_pkg::cpu_rsp_t         cpu_rsp;
    cfg_ram_pkg::eng_rd_t          eng = '0;
    logic                          eng_active = 1'b0;
    logic [`CFG_DATA_BITS-1:0]     eng_rdd;
    logic                          par_flag;

    // Command file image and its length
    logic [79:0]                   tdata [MAX_LINES];
    int                            line_count;

    // Engine traffic source
    logic                          eng_on = 1'b0;
    logic [16:0]                   lfsr;
    logic [3:0]                    ra_bits;
    logic                          act_a;
    logic                          act_b;

    // Reference model state
    logic [`CFG_DATA_BITS-1:0]     shadow [2 ** `CFG_ADDR_BITS];
    logic                          prev_cs;
    logic                          first_now;
    logic                          wr_now;
    logic                          w1;
    logic                          w2;
    logic                          exp1_v;
    logic                          exp2_v;
    logic [`CFG_DATA_BITS-1:0]     exp1_d;
    logic [`CFG_DATA_BITS-1:0]     exp2_d;

    cfg_ram_sys dut
    (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .eng        (eng),
        .eng_active (eng_active),
        .eng_rdd    (eng_rdd),
        .par_flag   (par_flag)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL time=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            report_failure("Value mismatch, stopping at the first error");
        end
    endtask

    // Maximal length with taps 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        lfsr_next = {s[15:0], s[16] ^ s[13]};
    endfunction

    // Fill word built from every address bit
    function automatic logic [31:0] fill_word(input logic [4:0] a);
        fill_word = {3'b101, a, 3'b011, a, 3'b110, a, 3'b001, a};
    endfunction

    //////////////////////////////////////////////////
    // CPU bus master
    //////////////////////////////////////////////////

    // Holds cs until rdy and idles one cycle after
    task automatic cpu_access(input logic wr, input logic page,
                              input logic [`CFG_ADDR_BITS-1:0] addr,
                              input logic [31:0] data,
                              output logic [31:0] rdata, output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        @(posedge clk);
        cpu_req.cs    <= 1'b1;
        cpu_req.wr    <= wr;
        cpu_req.page  <= page;
        cpu_req.addr  <= addr;
        cpu_req.wdata <= data;
        while (!seen)
        begin
            @(negedge clk);
            if (cpu_rsp.rdy)
            begin
                seen = 1'b1;
            end
            else
            begin
                cycles++;
                if (cycles > RDY_LIMIT)
                begin
                    report_failure("CPU request never got a ready pulse");
                end
            end
        end
        rdata = cpu_rsp.rdata;
        @(posedge clk);
        cpu_req <= '0;
    endtask

    //////////////////////////////////////////////////
    // Engine traffic
    //////////////////////////////////////////////////

    // Engine stays in the lower half and leaves the upper half to parity tests
    always @(posedge clk)
    begin
        if (rst || !eng_on)
        begin
            lfsr       = 17'd89832;
            eng        <= '0;
            eng_active <= 1'b0;
        end
        else
        begin
            lfsr = lfsr_next(lfsr);
            eng.re <= lfsr[0];
            lfsr = lfsr_next(lfsr);
            act_a = lfsr[0];
            lfsr = lfsr_next(lfsr);
            act_b = lfsr[0];
            eng_active <= act_a | act_b;
            for (int i = 0; i < 4; i++)
            begin
                lfsr = lfsr_next(lfsr);
                ra_bits[i] = lfsr[0];
            end
            eng.ra <= `CFG_ADDR_BITS'(ra_bits);
        end
    end

    //////////////////////////////////////////////////
    // Reference model stepped once per cycle
    //////////////////////////////////////////////////

    // Inputs and outputs are settled at the falling edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            prev_cs = 1'b0;
            w1      = 1'b0;
            w2      = 1'b0;
            exp1_v  = 1'b0;
            exp2_v  = 1'b0;
        end
        else
        begin
            // Engine result from two cycles back
            if (exp2_v)
            begin
                check_value("eng_rdd", eng_rdd, exp2_d);
            end
            exp2_v = exp1_v;
            exp2_d = exp1_d;

            // RAM write lands two cycles after the first cs cycle
            first_now = cpu_req.cs & ~prev_cs;
            prev_cs   = cpu_req.cs;
            wr_now    = w2;
            w2        = w1;
            w1        = first_now & cpu_req.wr & ~cpu_req.page;
            if (wr_now)
            begin
                shadow[cpu_req.addr] = cpu_req.wdata;
            end

            // Same-address write kills the engine read
            exp1_v = eng.re & eng_active & ~(wr_now & (cpu_req.addr == eng.ra));
            exp1_d = shadow[eng.ra];
        end
    end

    //////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////

    initial
    begin
        wait (line_count > 0);
        repeat ((line_count + INIT_WORDS) * 100) @(posedge clk);
        report_failure("Watchdog expired before the command list finished");
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        logic [79:0]                rec;
        logic [3:0]                 cmd;
        logic                       page;
        logic [`CFG_ADDR_BITS-1:0]  addr;
        logic [31:0]                data;
        logic [31:0]                exp;
        logic [31:0]                rdata;
        int                         cycles;

        clk        = 1'b0;
        line_count = 0;
        for (int i = 0; i < MAX_LINES; i++)
        begin
            tdata[i] = '0;
        end
        $readmemh("tests/cfg_ram_testdata.txt", tdata);
        while (line_count < MAX_LINES && tdata[line_count][79:76] != 4'd0)
        begin
            line_count++;
        end
        if (line_count == 0)
        begin
            report_failure("Command file is empty or missing");
        end

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Quiet outputs straight after reset
        @(negedge clk);
        check_value("cpu_rsp.rdy", {31'd0, cpu_rsp.rdy}, 32'd0);
        check_value("par_flag", {31'd0, par_flag}, 32'd0);

        // Known contents for every word the engine can reach
        for (int i = 0; i < INIT_WORDS; i++)
        begin
            cpu_access(1'b1, 1'b0, `CFG_ADDR_BITS'(i), fill_word(5'(i)), rdata, cycles);
        end
        @(posedge clk);
        eng_on <= 1'b1;

        for (int n = 0; n < line_count; n++)
        begin
            rec  = tdata[n];
            cmd  = rec[79:76];
            page = rec[72];
            addr = rec[64 +: `CFG_ADDR_BITS];
            data = rec[63:32];
            exp  = rec[31:0];
            case (cmd)
                4'd1:
                begin
                    cpu_access(1'b1, page, addr, data, rdata, cycles);
                    // Write ready takes 5 cycles on the RAM page and 1 on the status page
                    check_value("write ready delay", cycles, page ? 32'd1 : 32'd5);
                end
                4'd2:
                begin
                    cpu_access(1'b0, page, addr, data, rdata, cycles);
                    check_value("cpu_rsp.rdata", rdata, exp);
                    if (!page)
                    begin
                        check_value("cpu_rsp.rdata vs shadow", rdata, shadow[addr]);
                    end
                end
                4'd3:
                begin
                    @(negedge clk);
                    check_value("par_flag", {31'd0, par_flag}, exp);
                end
                4'd4:
                begin
                    repeat (data) @(posedge clk);
                end
                default:
                begin
                    report_failure("Unknown command in the command file");
                end
            endcase
        end

        // Let the last engine reads come back
        repeat (4) @(posedge clk);
        @(negedge clk);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* cfg_ram_sys.f */
+incdir+source
source/cfg_ram_pkg.sv
source/cpu_bus_decode.sv
source/cfg_ram_access.sv
source/cfg_ram_store.sv
source/cfg_status_regs.sv
source/cfg_ram_sys.sv
tests/cfg_ram_sys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the config RAM testbench with Verilator, runs it and decides pass or fail from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    -f cfg_ram_sys.f \
    --top-module cfg_ram_sys_tb \
    -Mdir obj_dir \
    -o cfg_ram_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cfg_ram_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tests/cfg_ram_testdata.txt */
// cmd_page_addr_data_expected, all hex: cmd 1 write, 2 read, 3 check par_flag, 4 idle data cycles
// page 0 is the RAM and page 1 the status registers, expected is used by cmd 2 and 3
3_0_00_00000000_00000000
2_1_00_00000000_00000000
2_1_01_00000000_00000000
1_0_03_DEADBEEF_00000000
2_0_03_00000000_DEADBEEF
1_0_07_12345678_00000000
1_0_0A_CAFEF00D_00000000
1_0_0F_0F1E2D3C_00000000
2_0_07_00000000_12345678
2_0_0A_00000000_CAFEF00D
4_0_00_00000010_00000000
2_0_0F_00000000_0F1E2D3C
2_0_03_00000000_DEADBEEF
1_0_03_A5A5A5A5_00000000
2_0_03_00000000_A5A5A5A5
1_0_00_00000001_00000000
2_0_00_00000000_00000001
1_0_14_00C0FFEE_00000000
1_1_00_00000001_00000000
2_1_00_00000000_00000001
1_0_14_13572468_00000000
1_1_00_00000000_00000000
2_1_00_00000000_00000000
3_0_00_00000000_00000000
2_0_14_00000000_13572468
4_0_00_00000004_00000000
3_0_00_00000000_00000001
2_1_01_00000000_00000001
1_1_01_00000001_00000000
2_1_01_00000000_00000000
3_0_00_00000000_00000000
1_1_00_00000002_00000000
2_1_00_00000000_00000002
2_0_14_00000000_13572468
4_0_00_00000004_00000000
3_0_00_00000000_00000000
2_1_01_00000000_00000000
1_1_00_00000000_00000000
1_0_14_13572468_00000000
2_0_14_00000000_13572468
4_0_00_00000004_00000000
3_0_00_00000000_00000000
